//--- design/bfp_pkg.sv
`default_nettype none

package bfp_pkg;

  // Exponent field of a single-precision word
  localparam int EXP_W = 8;

  // Leading mantissa bits kept per element
  localparam int MAN_KEEP = 3;

  // Sign, exponent and kept mantissa as one slice
  localparam int FIELD_W = 1 + EXP_W + MAN_KEEP;

  // Hidden one, kept mantissa and one guard zero
  localparam int MAG_W = MAN_KEEP + 2;

  // Sign followed by aligned magnitude
  localparam int ELEM_W = 1 + MAG_W;

  // Incoming single-precision word
  localparam int WORD_W = 32;

  // Exponent field, also used for the shared exponent
  typedef logic [EXP_W-1:0] exp_t;

  // Top slice of one word, sign in the MSB
  typedef logic [FIELD_W-1:0] field_t;

  // One quantized element
  typedef logic [ELEM_W-1:0] elem_t;

  // Registered levels of the max tree, ceil(log2(n))
  // Top-level latency is this plus two
  function automatic int tree_depth(input int n);
    int d;
    d = 0;
    while ((1 << d) < n) begin
      d++;
    end
    return d;
  endfunction

endpackage

`default_nettype wire

//--- design/exp_max_tree.sv
`timescale 1ns/1ps
`default_nettype none

module exp_max_tree #(
  parameter int N_ELEM = 32
) (
  input  logic                             clk_i,
  input  logic [N_ELEM*bfp_pkg::EXP_W-1:0] exps_i,
  output bfp_pkg::exp_t                    max_exp_o
);

  import bfp_pkg::*;

  // Internal nodes of a complete binary tree over N_ELEM leaves
  localparam int N_NODE = N_ELEM - 1;

  // Heap order: node k has children 2k+1 and 2k+2
  // Heap indices N_NODE and up are the leaves
  exp_t leaf [N_ELEM];

  // One register per internal node
  // Every leaf-to-root path crosses log2(N_ELEM) of them
  exp_t node_q [N_NODE];

  genvar k;

  generate
    // Unpack the flat exponent bus, element k in slice k
    for (k = 0; k < N_ELEM; k++) begin : g_leaf
      assign leaf[k] = exps_i[k*EXP_W +: EXP_W];
    end

    for (k = 0; k < N_NODE; k++) begin : g_node
      exp_t left;
      exp_t right;

      // With N_ELEM a power of two both children are
      // either leaves or internal nodes, never mixed
      if (2*k + 1 >= N_NODE) begin : g_from_leaf
        assign left  = leaf[2*k + 1 - N_NODE];
        assign right = leaf[2*k + 2 - N_NODE];
      end else begin : g_from_node
        assign left  = node_q[2*k + 1];
        assign right = node_q[2*k + 2];
      end

      // Plain unsigned compare on the biased field
      // An all-ones exponent simply wins like any other
      always_ff @(posedge clk_i) begin
        if (left >= right) begin
          node_q[k] <= left;
        end else begin
          node_q[k] <= right;
        end
      end
    end
  endgenerate

  // Root holds the block maximum, qualified downstream by the delayed valid
  assign max_exp_o = node_q[0];

endmodule

`default_nettype wire

//--- design/field_delay_line.sv
`timescale 1ns/1ps
`default_nettype none

module field_delay_line #(
  parameter int N_ELEM = 32
) (
  input  logic                               clk_i,
  input  logic                               rst_i,
  input  logic                               valid_i,
  input  logic [N_ELEM*bfp_pkg::FIELD_W-1:0] fields_i,
  output logic                               valid_o,
  output logic [N_ELEM*bfp_pkg::FIELD_W-1:0] fields_o
);

  import bfp_pkg::*;

  // Same number of stages as the max tree has levels
  localparam int DEPTH = tree_depth(N_ELEM);

  logic [N_ELEM*FIELD_W-1:0] fields_q [DEPTH];
  logic [DEPTH-1:0]          valid_q;

  // Valid chain, cleared so no stale block pops out after reset
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      valid_q <= '0;
    end else begin
      valid_q[0] <= valid_i;
      for (int s = 1; s < DEPTH; s++) begin
        valid_q[s] <= valid_q[s-1];
      end
    end
  end

  // Payload chain, shifts every cycle
  always_ff @(posedge clk_i) begin
    fields_q[0] <= fields_i;
    for (int s = 1; s < DEPTH; s++) begin
      fields_q[s] <= fields_q[s-1];
    end
  end

  // Last stage lines up with the tree root
  assign fields_o = fields_q[DEPTH-1];
  assign valid_o  = valid_q[DEPTH-1];

endmodule

`default_nettype wire

//--- design/elem_quantizer.sv
`timescale 1ns/1ps
`default_nettype none

module elem_quantizer #(
  parameter int N_ELEM = 32
) (
  input  logic                               clk_i,
  input  logic                               rst_i,
  input  logic                               valid_i,
  input  bfp_pkg::exp_t                      max_exp_i,
  input  logic [N_ELEM*bfp_pkg::FIELD_W-1:0] fields_i,
  output logic                               valid_o,
  output bfp_pkg::exp_t                      x_o,
  output logic [N_ELEM*bfp_pkg::ELEM_W-1:0]  p_o
);

  import bfp_pkg::*;

  // One element against the shared exponent
  // Field layout: sign, exponent, kept mantissa from MSB down
  function automatic elem_t quantize(input field_t f, input exp_t shared);
    logic             sign;
    exp_t             exp_f;
    exp_t             diff;
    logic [MAG_W-1:0] mag_full;
    logic [MAG_W-1:0] mag;
    sign     = f[FIELD_W-1];
    exp_f    = f[MAN_KEEP +: EXP_W];
    // Hidden one, mantissa, trailing zero
    mag_full = {1'b1, f[MAN_KEEP-1:0], 1'b0};
    // Never negative, shared is the block maximum
    diff     = shared - exp_f;
    if (exp_f == '0) begin
      // Zero or denormal input flushes to zero
      mag = '0;
    end else if (diff >= exp_t'(MAG_W)) begin
      // Everything shifted out
      mag = '0;
    end else begin
      // Truncating alignment, no rounding
      mag = mag_full >> diff;
    end
    // Sign kept even when the magnitude is zero
    return {sign, mag};
  endfunction

  logic [N_ELEM*ELEM_W-1:0] elems_d;

  genvar k;

  generate
    for (k = 0; k < N_ELEM; k++) begin : g_elem
      assign elems_d[k*ELEM_W +: ELEM_W] =
        quantize(fields_i[k*FIELD_W +: FIELD_W], max_exp_i);
    end
  endgenerate

  // Output valid
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      valid_o <= 1'b0;
    end else begin
      valid_o <= valid_i;
    end
  end

  // Shared exponent and elements leave together
  // Only meaningful while valid_o is high
  always_ff @(posedge clk_i) begin
    x_o <= max_exp_i;
    p_o <= elems_d;
  end

endmodule

`default_nettype wire

//--- design/bfp_quant_top.sv
`timescale 1ns/1ps
`default_nettype none

module bfp_quant_top #(
  parameter int N_ELEM = 32
) (
  input  logic                              clk_i,
  input  logic                              rst_i,
  input  logic                              valid_i,
  input  logic [N_ELEM*bfp_pkg::WORD_W-1:0] block_i,
  output logic                              valid_o,
  output bfp_pkg::exp_t                     x_o,
  output logic [N_ELEM*bfp_pkg::ELEM_W-1:0] p_o
);

  import bfp_pkg::*;

  // Stage 0, the input register
  logic [N_ELEM*WORD_W-1:0]  block_q;
  logic                      valid_q;

  // Slices of the stage-0 block
  logic [N_ELEM*EXP_W-1:0]   exps_s0;
  logic [N_ELEM*FIELD_W-1:0] fields_s0;

  // Aligned outputs of the two parallel parts
  exp_t                      max_exp;
  logic [N_ELEM*FIELD_W-1:0] fields_dly;
  logic                      valid_dly;

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      valid_q <= 1'b0;
    end else begin
      valid_q <= valid_i;
    end
  end

  always_ff @(posedge clk_i) begin
    block_q <= block_i;
  end

  genvar k;

  generate
    for (k = 0; k < N_ELEM; k++) begin : g_slice
      // Bits 30:23 of word k
      assign exps_s0[k*EXP_W +: EXP_W] = block_q[k*WORD_W + WORD_W - 1 - EXP_W +: EXP_W];
      // Bits 31:20 of word k, lower mantissa dropped
      assign fields_s0[k*FIELD_W +: FIELD_W] = block_q[k*WORD_W + WORD_W - FIELD_W +: FIELD_W];
    end
  endgenerate

  // Shared exponent after tree_depth cycles
  exp_max_tree #(
    .N_ELEM   (N_ELEM)
  ) exp_max_tree_i (
    .clk_i    (clk_i),
    .exps_i   (exps_s0),
    .max_exp_o(max_exp)
  );

  // Fields and valid held back to meet the tree root
  field_delay_line #(
    .N_ELEM  (N_ELEM)
  ) field_delay_line_i (
    .clk_i   (clk_i),
    .rst_i   (rst_i),
    .valid_i (valid_q),
    .fields_i(fields_s0),
    .valid_o (valid_dly),
    .fields_o(fields_dly)
  );

  elem_quantizer #(
    .N_ELEM   (N_ELEM)
  ) elem_quantizer_i (
    .clk_i    (clk_i),
    .rst_i    (rst_i),
    .valid_i  (valid_dly),
    .max_exp_i(max_exp),
    .fields_i (fields_dly),
    .valid_o  (valid_o),
    .x_o      (x_o),
    .p_o      (p_o)
  );

endmodule

`default_nettype wire

//--- testbench/bfp_quant_checker.sv
`timescale 1ns/1ps
`default_nettype none

module bfp_quant_checker #(
  parameter int N_ELEM = 32
) (
  input  logic                              clk_i,
  input  logic                              rst_i,
  input  logic                              in_valid_i,
  input  logic                              out_valid_i,
  input  bfp_pkg::exp_t                     out_exp_i,
  input  logic [N_ELEM*bfp_pkg::ELEM_W-1:0] out_elems_i
);

  // Input register, tree levels, output register
  localparam int LATENCY = $clog2(N_ELEM) + 2;

  // Cycles since reset saturating once the pipe holds only real inputs
  int settle_cnt;

  // Failed assertions so far
  int assert_err_cnt = 0;

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      settle_cnt <= 0;
    end else if (settle_cnt < LATENCY) begin
      settle_cnt <= settle_cnt + 1;
    end
  end

  // Valid pipeline is cleared by reset
  assert property (@(posedge clk_i) rst_i |=> !out_valid_i)
    else begin
      $error("valid_o high in the cycle after reset");
      assert_err_cnt++;
    end

  // One output pulse per input pulse at a fixed delay with nothing dropped or added
  assert property (@(posedge clk_i) disable iff (rst_i)
    (settle_cnt == LATENCY) |-> (out_valid_i == $past(in_valid_i, LATENCY)))
    else begin
      $error("valid_o does not follow valid_i by the pipeline latency");
      assert_err_cnt++;
    end

  // Results fully known whenever they are qualified
  assert property (@(posedge clk_i) disable iff (rst_i)
    out_valid_i |-> !$isunknown({out_exp_i, out_elems_i}))
    else begin
      $error("x_o or p_o holds unknown bits while valid_o is high");
      assert_err_cnt++;
    end

endmodule

bind bfp_quant_top bfp_quant_checker #(
  .N_ELEM     (N_ELEM)
) bfp_quant_checker_i (
  .clk_i      (clk_i),
  .rst_i      (rst_i),
  .in_valid_i (valid_i),
  .out_valid_i(valid_o),
  .out_exp_i  (x_o),
  .out_elems_i(p_o)
);

`default_nettype wire

//--- testbench/bfp_quant_tb.sv
`timescale 1ns/1ps
`default_nettype none

module bfp_quant_tb;

  import bfp_pkg::*;

  localparam int N_ELEM       = 8;
  localparam int LATENCY      = $clog2(N_ELEM) + 2;
  localparam int CLK_PERIOD   = 8;
  localparam int RESET_CYCLES = 16;
  localparam int IDLE_CYCLES  = 10;
  // Gap, words, shared exponent, elements
  localparam int TOKENS       = 2 + 2 * N_ELEM;
  localparam int MAX_FILE     = 32;
  localparam int N_RANDOM     = 24;
  localparam int RAND_GAP_MAX = 3;

  logic                     clk;
  logic                     rst;
  logic                     valid_in;
  logic [N_ELEM*WORD_W-1:0] block_in;
  logic                     valid_out;
  exp_t                     x_out;
  logic [N_ELEM*ELEM_W-1:0] p_out;

  logic [31:0] test_mem [MAX_FILE*TOKENS];

  // Blocks in flight with the oldest first
  int                       exp_id_q[$];
  exp_t                     exp_x_q[$];
  logic [N_ELEM*ELEM_W-1:0] exp_p_q[$];
  int                       exp_cycle_q[$];

  int          cycle_cnt   = 0;
  int          cycle_limit = 0;
  int          err_cnt     = 0;
  int          pass_cnt    = 0;
  int          fail_cnt    = 0;
  int          n_file_tests;
  logic [31:0] lcg_state;

  bfp_quant_top #(
    .N_ELEM (N_ELEM)
  ) bfp_quant_top_i (
    .clk_i  (clk),
    .rst_i  (rst),
    .valid_i(valid_in),
    .block_i(block_in),
    .valid_o(valid_out),
    .x_o    (x_out),
    .p_o    (p_out)
  );

  initial begin
    clk = 1'b0;
    forever begin
      #(CLK_PERIOD / 2) clk = ~clk;
    end
  end

  always @(posedge clk) begin
    cycle_cnt <= cycle_cnt + 1;
  end

  // Numerical Recipes constants
  function automatic logic [31:0] lcg_next(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  // Largest exponent field found in bits 30:23 of each word
  function automatic exp_t ref_shared_exp(input logic [N_ELEM*WORD_W-1:0] blk);
    exp_t best;
    int   k;
    best = '0;
    for (k = 0; k < N_ELEM; k++) begin
      if (blk[k*WORD_W + 23 +: EXP_W] > best) begin
        best = blk[k*WORD_W + 23 +: EXP_W];
      end
    end
    return best;
  endfunction

  // Sign kept and 1.mmm0 divided down by 2^diff with truncation
  function automatic elem_t ref_element(input logic [31:0] word, input exp_t shared);
    int e;
    int m;
    int shift;
    int mag;
    e     = int'(word[30:23]);
    m     = int'(word[22:20]);
    shift = int'(shared) - e;
    if (e == 0 || shift > 4) begin
      mag = 0;
    end else begin
      mag = (16 + 2 * m) / (1 << shift);
    end
    return {word[31], 5'(mag)};
  endfunction

  // Exponents clustered under a random base so every shift shows up
  task automatic make_random_block(output logic [N_ELEM*WORD_W-1:0] blk);
    exp_t       base;
    exp_t       e;
    logic [2:0] off;
    int         k;
    lcg_state = lcg_next(lcg_state);
    base      = lcg_state[23:16];
    for (k = 0; k < N_ELEM; k++) begin
      lcg_state = lcg_next(lcg_state);
      // Upper LCG bits have the longer period
      off = lcg_state[30:28];
      e   = (base > exp_t'(off)) ? base - exp_t'(off) : '0;
      // About one word in eight becomes zero or denormal
      if (lcg_state[27:25] == 3'd0) begin
        e = '0;
      end
      blk[k*WORD_W +: WORD_W] = {lcg_state[31], e, lcg_state[22:0]};
    end
  endtask

  // Idle gap then one valid cycle
  task automatic send_block(input int id, input int gap,
                            input logic [N_ELEM*WORD_W-1:0] blk,
                            input exp_t x, input logic [N_ELEM*ELEM_W-1:0] p);
    repeat (gap) begin
      @(posedge clk);
      #1;
      valid_in = 1'b0;
    end
    @(posedge clk);
    #1;
    valid_in = 1'b1;
    block_in = blk;
    // Expectation queued along with the send cycle
    exp_id_q.push_back(id);
    exp_x_q.push_back(x);
    exp_p_q.push_back(p);
    exp_cycle_q.push_back(cycle_cnt);
  endtask

  // Compare one output pulse against the oldest block in flight
  task automatic check_result();
    int                       id;
    exp_t                     ex;
    logic [N_ELEM*ELEM_W-1:0] ep;
    int                       sc;
    int                       k;
    logic                     bad;
    id  = exp_id_q.pop_front();
    ex  = exp_x_q.pop_front();
    ep  = exp_p_q.pop_front();
    sc  = exp_cycle_q.pop_front();
    bad = 1'b0;
    assert (cycle_cnt - sc == LATENCY) else begin
      $display("block %0d came out %0d cycles after it was sent instead of %0d",
               id, cycle_cnt - sc, LATENCY);
      bad = 1'b1;
    end
    assert (x_out === ex) else begin
      $display("[ERROR] %0t x_o: got %h, expected %h", $time, x_out, ex);
      bad = 1'b1;
    end
    for (k = 0; k < N_ELEM; k++) begin
      assert (p_out[k*ELEM_W +: ELEM_W] === ep[k*ELEM_W +: ELEM_W]) else begin
        $display("[ERROR] %0t p_o[%0d]: got %h, expected %h", $time, k,
                 p_out[k*ELEM_W +: ELEM_W], ep[k*ELEM_W +: ELEM_W]);
        bad = 1'b1;
      end
    end
    if (bad) begin
      err_cnt++;
      fail_cnt++;
      $display("test %0d (%s): FAILED", id, (id < n_file_tests) ? "file" : "random");
    end else begin
      pass_cnt++;
      $display("test %0d (%s): ok, x_o=%h", id, (id < n_file_tests) ? "file" : "random", ex);
    end
  endtask

  // Sample mid-cycle away from the clock edge
  always @(negedge clk) begin
    if (!rst) begin
      assert (!$isunknown(valid_out)) else begin
        $display("valid_o is unknown at %0t", $time);
        err_cnt++;
      end
      if (valid_out === 1'b1) begin
        assert (exp_id_q.size() != 0) else begin
          $display("valid_o pulsed at %0t with no block in flight", $time);
          err_cnt++;
        end
        if (exp_id_q.size() != 0) begin
          check_result();
        end
      end
    end
  end

  // Watchdog armed once the test length is known
  initial begin
    wait (cycle_limit > 0);
    while (cycle_cnt < cycle_limit) begin
      @(posedge clk);
    end
    $display("timeout after %0d cycles with %0d blocks still in flight",
             cycle_cnt, exp_id_q.size());
    $display("TEST RESULT: FAIL");
    $finish;
  end

  initial begin
    int                       i;
    int                       k;
    int                       id;
    int                       base;
    int                       gap;
    int                       max_gap;
    int                       chk_errs;
    logic                     idle_bad;
    logic [N_ELEM*WORD_W-1:0] blk;
    exp_t                     x;
    logic [N_ELEM*ELEM_W-1:0] p;

    rst       = 1'b1;
    valid_in  = 1'b0;
    block_in  = '0;
    lcg_state = 32'h9813;
    idle_bad  = 1'b0;

    // All-ones gap word marks the end of the file
    for (i = 0; i < MAX_FILE * TOKENS; i++) begin
      test_mem[i] = '1;
    end
    $readmemh("testbench/bfp_quant_tests.txt", test_mem);
    n_file_tests = 0;
    while (n_file_tests < MAX_FILE && test_mem[n_file_tests*TOKENS] !== 32'hFFFF_FFFF) begin
      n_file_tests++;
    end
    assert (n_file_tests > 0) else begin
      $display("no tests could be read from testbench/bfp_quant_tests.txt");
      err_cnt++;
    end

    max_gap = RAND_GAP_MAX;
    for (id = 0; id < n_file_tests; id++) begin
      if (int'(test_mem[id*TOKENS]) > max_gap) begin
        max_gap = int'(test_mem[id*TOKENS]);
      end
    end
    cycle_limit = RESET_CYCLES + IDLE_CYCLES
                + (n_file_tests + N_RANDOM) * (max_gap + 1 + LATENCY) + 100;

    repeat (RESET_CYCLES) @(posedge clk);
    #1;
    rst = 1'b0;

    // Nothing may come out before the first block
    repeat (IDLE_CYCLES) begin
      @(negedge clk);
      assert (valid_out === 1'b0) else begin
        $display("valid_o rose at %0t before any block was sent", $time);
        idle_bad = 1'b1;
      end
    end
    if (idle_bad) begin
      err_cnt++;
      fail_cnt++;
      $display("test idle after reset: FAILED");
    end else begin
      pass_cnt++;
      $display("test idle after reset: ok");
    end

    // Directed blocks with off-line expected values
    for (id = 0; id < n_file_tests; id++) begin
      base = id * TOKENS;
      gap  = int'(test_mem[base]);
      for (k = 0; k < N_ELEM; k++) begin
        blk[k*WORD_W +: WORD_W] = test_mem[base + 1 + k];
        p[k*ELEM_W +: ELEM_W]   = elem_t'(test_mem[base + 2 + N_ELEM + k]);
      end
      x = exp_t'(test_mem[base + 1 + N_ELEM]);
      send_block(id, gap, blk, x, p);
    end

    // Random blocks checked against the reference model
    for (id = n_file_tests; id < n_file_tests + N_RANDOM; id++) begin
      make_random_block(blk);
      lcg_state = lcg_next(lcg_state);
      gap       = int'(lcg_state[17:16]);
      x         = ref_shared_exp(blk);
      for (k = 0; k < N_ELEM; k++) begin
        p[k*ELEM_W +: ELEM_W] = ref_element(blk[k*WORD_W +: WORD_W], x);
      end
      send_block(id, gap, blk, x, p);
    end

    @(posedge clk);
    #1;
    valid_in = 1'b0;

    while (exp_id_q.size() != 0) begin
      @(negedge clk);
    end
    // Extra pulses after the last block are caught by the monitor
    repeat (LATENCY + 2) @(negedge clk);

    // Failures of the bound protocol assertions
    chk_errs = bfp_quant_top_i.bfp_quant_checker_i.assert_err_cnt;

    $display("%0d tests: %0d passed, %0d failed, %0d errors, %0d assertion failures",
             n_file_tests + N_RANDOM + 1, pass_cnt, fail_cnt, err_cnt, chk_errs);
    if (err_cnt == 0 && fail_cnt == 0 && chk_errs == 0
        && pass_cnt == n_file_tests + N_RANDOM + 1) begin
      $display("TEST RESULT: PASS");
    end else begin
      $display("TEST RESULT: FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- testbench/bfp_quant_tests.txt
// One block per line, all values hex
// gap: idle cycles before the block, then words 0..7 (IEEE single)
// then expected x_o (shared exponent) and expected elements 0..7 (sign, 5-bit magnitude)
// Unity exponent, every kept mantissa pattern
0 3F800000 BF800000 3FF00000 BFC00000 3FA12345 3F9FFFFF BFB00001 3FE80000 7F 10 30 1E 38 14 12 36 1C
// Shifts of 1 to 4, shifted out at 5, negative zero
0 40000000 3F800000 3F700000 BED00000 3E700000 3DF00000 BDF00000 80000000 80 10 08 07 23 01 00 20 20
// Largest exponent on negative words and repeated, one zero exponent
0 C2A00000 42D00000 42000000 C1E00000 00300000 40900000 40700000 C2F00000 85 34 1A 08 27 00 01 00 3E
// All-ones exponent handled as an ordinary exponent
3 7F800000 FFC00000 7F000000 3F800000 FE600000 7E900000 00000000 7DF00000 FF 10 38 08 00 23 04 00 01
// Zero block, signs of negative zeros kept
0 00000000 80000000 00000000 80000000 000FFFFF 80012345 00000000 80000000 00 00 20 00 20 00 20 00 20
// Smallest normal exponent next to denormals
1 00800000 80D00000 00700000 00F00000 80A00000 80700000 00100000 00B00000 01 10 3A 00 1E 34 20 00 16
// Maximum in the last word, staircase down to a difference of 7
0 47B00000 C7300000 46B00000 46300000 45B00000 C5300000 44B00000 48300000 90 0B 25 02 01 00 20 00 16
// Maximum in the middle, truncation of odd magnitudes
5 37900000 37E00000 B7600000 36900000 38100000 B6000000 36700000 B8000000 70 09 0E 27 02 12 21 01 30
// Mixed differences below a mid-range exponent
2 A0512345 1F400000 9FF00000 1E400000 1EF00000 20000000 9DF00000 00800000 40 3A 06 2F 01 03 10 20 00
// Same negative word everywhere
0 C0A00000 C0A00000 C0A00000 C0A00000 C0A00000 C0A00000 C0A00000 C0A00000 81 34 34 34 34 34 34 34 34

//--- bfp_quant.f
design/bfp_pkg.sv
design/exp_max_tree.sv
design/field_delay_line.sv
design/elem_quantizer.sv
design/bfp_quant_top.sv
testbench/bfp_quant_checker.sv
testbench/bfp_quant_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Build the bfp_quant testbench with Verilator and run it
# The run counts as passed only if the log holds the pass message

cd "$(dirname "$0")" || exit 1

BUILD_LOG=build.log
SIM_LOG=sim.log

rm -rf obj_dir "$BUILD_LOG" "$SIM_LOG"

verilator --binary --timing --assert -Wno-fatal \
  --top-module bfp_quant_tb -f bfp_quant.f -o bfp_quant_sim \
  > "$BUILD_LOG" 2>&1 \
  && ./obj_dir/bfp_quant_sim +verilator+error+limit+100 > "$SIM_LOG" 2>&1 \
  || { echo "build or simulation did not complete"; cat "$BUILD_LOG" "$SIM_LOG" 2>/dev/null; exit 1; }

cat "$SIM_LOG"

grep -q "^TEST RESULT: PASS$" "$SIM_LOG" \
  && echo "simulation passed" \
  || { echo "simulation failed"; exit 1; }
